//--- bpu.f
src/bpu_pkg.sv
src/pred_table.sv
src/dir_predictor.sv
src/target_predictor.sv
src/pred_combine.sv
src/bpu_top.sv
bench/bpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the branch predictor testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bpu_tb -f bpu.f \
    -Mdir obj_dir -o bpu_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/bpu_sim > sim.log 2>&1
cat sim.log
grep -qF "*** PASSED ***" sim.log && exit 0 || exit 1

//--- bench/bpu_input.txt
# P pc inst exp_is_ctrl exp_taken exp_target exp_provider exp_history
# R pc actual_taken actual_target    (hex fields, provider 0 bimodal, 1 tagged)
P 00000100 00000013 0 0 00000104 0 0000
P 00000200 00000863 1 0 00000204 0 0000
P 00000300 0200006f 1 1 00000320 0 0000
R 00000300 1 00000400
P 00000300 0200006f 1 1 00000400 0 0001
P 00000200 00000863 1 0 00000204 0 0001
R 00000200 1 00000210
P 00000200 00000863 1 1 00000210 0 0003
R 00000200 1 00000210
P 00000200 00000863 1 1 00000210 0 0007
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
P 00000100 00000013 0 0 00000104 0 0070
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
P 00000100 00000013 0 0 00000104 0 0700
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
P 00000100 00000013 0 0 00000104 0 7000
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
R 00000100 0 00000104
P 00000200 00000863 1 1 00000210 0 0000
R 00000200 0 00000204
P 00000200 00000863 1 0 00000204 1 0000
R 00000200 1 00000210
P 00000200 00000863 1 1 00000210 1 0001

//--- bench/bpu_tb.sv
`timescale 1ns/10ps

module bpu_tb import bpu_pkg::*; ();

    localparam int    CLK_HALF   = 4;
    localparam int    SAMPLE_DLY = 3; // just before the next rising edge
    localparam int    RST_CYCLES = 16;
    localparam string INPUT_FILE = "bench/bpu_input.txt";

    // one line of the input file
    typedef struct packed {
        logic            is_resolve;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        pred_t           exp_pred;
        logic            act_taken;
        logic [XLEN-1:0] act_target;
    } step_t;

    logic              clk = 1'b0;
    logic              rst;
    fetch_req_t        req;
    resolve_t          resolve;
    pred_t             pred;
    logic [HIST_W-1:0] history;

    step_t steps[$];
    pred_t seen_pred [logic [XLEN-1:0]]; // last observed prediction per pc
    int    cycle_count = 0;
    int    cycle_limit = 0;

    bpu_top #(
        .BIMODAL_ENTRIES (512),
        .TAGGED_ENTRIES  (256),
        .BTB_ENTRIES     (256)
    ) bpu_top_i (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req),
        .resolve_i (resolve),
        .pred_o    (pred),
        .history_o (history)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string pred_text(input pred_t p);
        return $sformatf("ctrl %0b taken %0b target %08h %s hist %04h",
                         p.is_ctrl, p.taken, p.target, p.provider.name(), p.history);
    endfunction

    task automatic check_pred(input pred_t got, input pred_t exp, input logic [XLEN-1:0] pc);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: pc %08h predicted %s, expected %s",
                                $time, pc, pred_text(got), pred_text(exp)));
        end
    endtask

    task automatic check_history(input logic [HIST_W-1:0] got, input logic [HIST_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: global history %04h, expected %04h",
                                $time, got, exp));
        end
    endtask

    task automatic load_steps();
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] f0, f1, f2, f3, f4, f5, f6;
        step_t           s;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the input file bench/bpu_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                s = '0;
                if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                    n = 0; // comment or blank
                end else if (line.getc(0) == "P") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                                f0, f1, f2, f3, f4, f5, f6);
                    if (n != 7) begin
                        abort_run({"badly formed prediction line: ", line});
                    end else begin
                        s.pc                = f0;
                        s.inst              = f1;
                        s.exp_pred.is_ctrl  = f2[0];
                        s.exp_pred.taken    = f3[0];
                        s.exp_pred.target   = f4;
                        s.exp_pred.provider = provider_e'(f5[0]);
                        s.exp_pred.history  = f6[HIST_W-1:0];
                        steps.push_back(s);
                    end
                end else if (line.getc(0) == "R") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f0, f1, f2);
                    if (n != 3) begin
                        abort_run({"badly formed resolve line: ", line});
                    end else begin
                        s.is_resolve = 1'b1;
                        s.pc         = f0;
                        s.act_taken  = f1[0];
                        s.act_target = f2;
                        steps.push_back(s);
                    end
                end else begin
                    abort_run({"unknown line kind in the input file: ", line});
                end
            end
            $fclose(fd);
        end
    endtask

    // resolve built from what the DUT predicted for this pc
    task automatic drive_resolve(input step_t s);
        pred_t p;
        if (!seen_pred.exists(s.pc)) begin
            abort_run($sformatf("resolve for pc %08h which was never predicted", s.pc));
        end else begin
            p = seen_pred[s.pc];
            resolve.valid      = 1'b1;
            resolve.pc         = s.pc;
            resolve.taken      = s.act_taken;
            resolve.target     = s.act_target;
            resolve.mispredict = (p.taken != s.act_taken) ||
                                 (s.act_taken && (p.target != s.act_target));
            resolve.provider   = p.provider;
            resolve.history    = p.history;
        end
    endtask

    task automatic run_predict(input step_t s);
        resolve  = '0;
        req.pc   = s.pc;
        req.inst = s.inst;
        #SAMPLE_DLY;
        check_pred(pred, s.exp_pred, s.pc);
        check_history(history, s.exp_pred.history);
        seen_pred[s.pc] = pred;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout, tests did not finish within %0d cycles",
                                cycle_limit));
        end
    end

    initial begin
        rst     = 1'b1;
        req     = '0;
        resolve = '0;
        load_steps();
        cycle_limit = 4 * steps.size() + 100;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[i]) begin
            @(negedge clk); // inputs change away from the sampling edge
            if (steps[i].is_resolve) begin
                drive_resolve(steps[i]);
            end else begin
                run_predict(steps[i]);
            end
        end
        @(negedge clk);
        resolve = '0;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- src/bpu_top.sv
`timescale 1ns/10ps

module bpu_top import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256,
    parameter int BTB_ENTRIES     = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  fetch_req_t        req_i,
    input  resolve_t          resolve_i,
    output pred_t             pred_o,
    output logic [HIST_W-1:0] history_o
);

    dir_pred_t       dir_pred;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;

    dir_predictor #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGGED_ENTRIES  (TAGGED_ENTRIES)
    ) dir_predictor_i (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (req_i.pc),
        .resolve_i (resolve_i),
        .dir_o     (dir_pred),
        .history_o (history_o)
    );

    target_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) target_predictor_i (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (req_i.pc),
        .resolve_i    (resolve_i),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target)
    );

    pred_combine pred_combine_i (
        .req_i        (req_i),
        .dir_i        (dir_pred),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

//--- src/pred_combine.sv
`timescale 1ns/10ps

module pred_combine import bpu_pkg::*; (
    input  fetch_req_t      req_i,
    input  dir_pred_t       dir_i,
    input  logic            btb_hit_i,
    input  logic [XLEN-1:0] btb_target_i,
    output pred_t           pred_o
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic            is_branch;
    logic            is_jal;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign is_branch = (req_i.inst[6:0] == OPC_BRANCH);
    assign is_jal    = (req_i.inst[6:0] == OPC_JAL);
    assign pc_plus4  = req_i.pc + XLEN'(4);

    // sign extended offsets, bit 0 always zero
    assign imm_b = {{20{req_i.inst[31]}}, req_i.inst[7], req_i.inst[30:25],
                    req_i.inst[11:8], 1'b0};
    assign imm_j = {{12{req_i.inst[31]}}, req_i.inst[19:12], req_i.inst[20],
                    req_i.inst[30:21], 1'b0};

    always_comb begin
        pred_o.is_ctrl  = 1'b0;
        pred_o.taken    = 1'b0;
        pred_o.target   = pc_plus4;
        pred_o.provider = dir_i.provider;
        pred_o.history  = dir_i.history;
        if (is_jal) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = 1'b1; // unconditional
            pred_o.target  = btb_hit_i ? btb_target_i : req_i.pc + imm_j;
        end else if (is_branch) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = dir_i.taken;
            if (dir_i.taken) begin
                pred_o.target = btb_hit_i ? btb_target_i : req_i.pc + imm_b;
            end
        end
    end

endmodule

//--- src/target_predictor.sv
`timescale 1ns/10ps

module target_predictor import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] pc_i,
    input  resolve_t        resolve_i,
    output logic            btb_hit_o,
    output logic [XLEN-1:0] btb_target_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    btb_entry_t rd_entry;
    btb_entry_t wr_entry;
    logic       wr_en;

    // lookup, index from the low word address bits and tag from the top
    assign btb_hit_o    = rd_entry.valid && (rd_entry.tag == pc_i[XLEN-1:XLEN-BTB_TAG_W]);
    assign btb_target_o = rd_entry.target;

    assign wr_en           = resolve_i.valid && resolve_i.taken; // only taken branches
    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = resolve_i.pc[XLEN-1:XLEN-BTB_TAG_W];
    assign wr_entry.target = resolve_i.target;

    pred_table #(
        .entry_t   (btb_entry_t),
        .DEPTH     (BTB_ENTRIES),
        .RESET_VAL ('0)
    ) btb_i (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (pc_i[IDX_W+1:2]),
        .rd_data_o (rd_entry),
        .wr_en_i   (wr_en),
        .wr_idx_i  (resolve_i.pc[IDX_W+1:2]),
        .wr_data_i (wr_entry)
    );

endmodule

//--- src/dir_predictor.sv
`timescale 1ns/10ps

module dir_predictor import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   pc_i,
    input  resolve_t          resolve_i,
    output dir_pred_t         dir_o,
    output logic [HIST_W-1:0] history_o
);

    localparam int BM_IDX_W = $clog2(BIMODAL_ENTRIES);
    localparam int TG_IDX_W = $clog2(TAGGED_ENTRIES);

    logic [HIST_W-1:0] ghist;

    logic [BM_IDX_W-1:0] bm_rd_idx;
    logic [BM_IDX_W-1:0] bm_upd_idx;
    ctr2_t               bm_ctr;
    ctr2_t               bm_upd_ctr;  // counter at the resolve pc
    ctr2_t               bm_wr_ctr;

    logic [TG_IDX_W-1:0] tg_rd_idx;
    logic [TG_IDX_W-1:0] tg_upd_idx;
    tage_entry_t         tg_entry;
    tage_entry_t         tg_wr_entry;
    logic                tg_wr_en;
    logic                tg_hit;

    // tagged table index, pc folded with the low history
    function automatic logic [TG_IDX_W-1:0] tg_index(input logic [XLEN-1:0] pc,
                                                      input logic [HIST_W-1:0] hist);
        return pc[TG_IDX_W+1:2] ^ hist[TG_IDX_W-1:0];
    endfunction

    // full tag from the pc bits above the index and the upper history
    function automatic logic [TAG_W-1:0] tg_tag(input logic [XLEN-1:0] pc,
                                                input logic [HIST_W-1:0] hist);
        return pc[TG_IDX_W+TAG_W+1:TG_IDX_W+2] ^ hist[HIST_W-1:HIST_W-TAG_W];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (resolve_i.valid) begin
            ghist <= {ghist[HIST_W-2:0], resolve_i.taken}; // newest outcome at bit 0
        end
    end

    assign history_o = ghist;

    // lookup
    assign bm_rd_idx = pc_i[BM_IDX_W+1:2];
    assign tg_rd_idx = tg_index(pc_i, ghist);
    assign tg_hit    = tg_entry.valid && (tg_entry.tag == tg_tag(pc_i, ghist));

    assign dir_o.taken    = tg_hit ? tg_entry.ctr[1] : bm_ctr[1];
    assign dir_o.provider = tg_hit ? PROV_TAGGED : PROV_BIMODAL;
    assign dir_o.history  = ghist;

    // training
    assign bm_upd_idx = resolve_i.pc[BM_IDX_W+1:2];
    assign bm_wr_ctr  = ctr_update(bm_upd_ctr, resolve_i.taken);
    assign tg_upd_idx = tg_index(resolve_i.pc, resolve_i.history);

    // a correct tagged provider already points at the outcome, so both the
    // saturate and the reset cases end on the strong counter value
    always_comb begin
        tg_wr_entry.valid = 1'b1;
        tg_wr_entry.tag   = tg_tag(resolve_i.pc, resolve_i.history);
        if (resolve_i.provider == PROV_TAGGED) begin
            tg_wr_entry.ctr = {resolve_i.taken, resolve_i.taken};
        end else begin
            tg_wr_entry.ctr = resolve_i.taken ? CTR_WEAK_T : CTR_WEAK_NT; // new entry
        end
    end

    assign tg_wr_en = resolve_i.valid &&
                      ((resolve_i.provider == PROV_TAGGED) || resolve_i.mispredict);

    pred_table #(
        .entry_t   (ctr2_t),
        .DEPTH     (BIMODAL_ENTRIES),
        .RESET_VAL (CTR_WEAK_NT)
    ) bimodal_i (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (bm_rd_idx),
        .rd_data_o (bm_ctr),
        .wr_en_i   (resolve_i.valid),
        .wr_idx_i  (bm_upd_idx),
        .wr_data_i (bm_wr_ctr)
    );

    // identical copy, gives the resolve its own read of the counters
    pred_table #(
        .entry_t   (ctr2_t),
        .DEPTH     (BIMODAL_ENTRIES),
        .RESET_VAL (CTR_WEAK_NT)
    ) bimodal_upd_i (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (bm_upd_idx),
        .rd_data_o (bm_upd_ctr),
        .wr_en_i   (resolve_i.valid),
        .wr_idx_i  (bm_upd_idx),
        .wr_data_i (bm_wr_ctr)
    );

    pred_table #(
        .entry_t   (tage_entry_t),
        .DEPTH     (TAGGED_ENTRIES),
        .RESET_VAL ('0)
    ) tagged_i (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (tg_rd_idx),
        .rd_data_o (tg_entry),
        .wr_en_i   (tg_wr_en),
        .wr_idx_i  (tg_upd_idx),
        .wr_data_i (tg_wr_entry)
    );

endmodule

//--- src/pred_table.sv
`timescale 1ns/10ps

module pred_table #(
    parameter type entry_t   = logic [1:0],
    parameter int  DEPTH     = 256,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    assign rd_data_o = mem[rd_idx_i]; // combinational read

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

//--- src/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN      = 32;
    localparam int HIST_W    = 16;
    localparam int TAG_W     = 10;
    localparam int BTB_TAG_W = 22;

    // 2-bit saturating counter, msb set means taken
    typedef logic [1:0] ctr2_t;

    localparam ctr2_t CTR_WEAK_NT = 2'b01; // bimodal reset value
    localparam ctr2_t CTR_WEAK_T  = 2'b10;

    typedef enum logic {
        PROV_BIMODAL = 1'b0,
        PROV_TAGGED  = 1'b1
    } provider_e;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        ctr2_t            ctr;
    } tage_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_req_t;

    typedef struct packed {
        logic              taken;
        provider_e         provider;
        logic [HIST_W-1:0] history; // history seen by the lookup
    } dir_pred_t;

    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [XLEN-1:0]   target;
        provider_e         provider;
        logic [HIST_W-1:0] history;
    } pred_t;

    // resolved branch from execute, provider and history echo the prediction
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic              taken;
        logic [XLEN-1:0]   target;
        logic              mispredict;
        provider_e         provider;
        logic [HIST_W-1:0] history;
    } resolve_t;

    // step a counter one place toward the outcome, holding at the ends
    function automatic ctr2_t ctr_update(input ctr2_t ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

endpackage
